// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;		// Data, address and instruction word
	typedef logic [2:0] reg_num_t;		// General register number
	typedef logic [3:0] flags_t;		// Status word flags

	typedef enum logic [3:0]
	{
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_XOR = 4'd3,
		OP_MOV = 4'd4,
		OP_MOVL = 4'd5,
		OP_MOVH = 4'd6,
		OP_LD = 4'd7,
		OP_ST = 4'd8,
		OP_BR = 4'd9,
		OP_SETCC = 4'd10,
		OP_CLRCC = 4'd11
	} opcode_t;							// Codes 12 to 15 do nothing

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_PASS} alu_op_t;

	localparam int FLAG_C = 0;			// Carry, set on no borrow for SUB
	localparam int FLAG_Z = 1;			// Zero
	localparam int FLAG_N = 2;			// Negative
	localparam int FLAG_V = 3;			// Signed overflow

	typedef enum logic [3:0]
	{
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_AL
	} cond_t;							// Codes 9 to 15 never branch

	typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_MEMORY, S_HALTED} seq_state_t;

	localparam word_t RESET_PC = 16'h0000;	// First fetch address
	localparam word_t PC_STEP = 16'd2;		// Byte addresses of words

endpackage

`default_nettype wire

// ==== hdl/cpu_interfaces.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic link between one master and the arbiter
interface wb_if;
	import cpu_pkg::*;

	word_t adr;
	word_t dat_w;
	word_t dat_r;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	modport master (output adr, dat_w, we, cyc, stb, input dat_r, ack);
	modport slave (input adr, dat_w, we, cyc, stb, output dat_r, ack);
endinterface

interface fetch_if;
	import cpu_pkg::*;

	logic valid;						// Buffer holds an instruction
	word_t instr;
	word_t pc;							// Address of instr
	logic take;							// Sequencer consumes instr
	logic redirect;						// One cycle, flushes the prefetch
	word_t target;

	modport fetch (output valid, instr, pc, input take, redirect, target);
	modport sequencer (input valid, instr, pc, output take, redirect, target);
endinterface

interface lsu_if;
	import cpu_pkg::*;

	logic start;						// One cycle request
	logic write;						// ST when high
	word_t addr;
	word_t wdata;
	word_t rdata;						// Valid with done
	logic done;

	modport unit (input start, write, addr, wdata, output rdata, done);
	modport sequencer (output start, write, addr, wdata, input rdata, done);
endinterface

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire cpu_pkg::alu_op_t op,
	input wire cpu_pkg::word_t a,
	input wire cpu_pkg::word_t b,
	input wire cpu_pkg::flags_t flags_in,
	output cpu_pkg::word_t result,
	output cpu_pkg::flags_t flags_out
);
	import cpu_pkg::*;

	word_t b_eff;						// b, or its inverse for SUB
	logic [16:0] sum;					// Carry in bit 16

	always_comb
	begin
		b_eff = (op == ALU_SUB) ? ~b : b;
		sum = {1'b0, a} + {1'b0, b_eff} + {16'd0, op == ALU_SUB};	// Plus one completes a - b
		flags_out = flags_in;			// PASS keeps everything
		case (op)
			ALU_ADD, ALU_SUB:
			begin
				result = sum[15:0];
				flags_out[FLAG_C] = sum[16];
				flags_out[FLAG_V] = (a[15] == b_eff[15]) && (sum[15] != a[15]);	// Same signs in, other out
			end
			ALU_AND:
			begin
				result = a & b;
				flags_out[FLAG_V] = 1'b0;	// C kept
			end
			ALU_XOR:
			begin
				result = a ^ b;
				flags_out[FLAG_V] = 1'b0;
			end
			default: result = b;		// MOV path
		endcase
		if (op != ALU_PASS)
		begin
			flags_out[FLAG_Z] = (result == '0);
			flags_out[FLAG_N] = result[15];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input wire clock,
	input wire reset,
	input wire cpu_pkg::reg_num_t rd_a,
	input wire cpu_pkg::reg_num_t rd_b,
	output cpu_pkg::word_t data_a,
	output cpu_pkg::word_t data_b,
	input wire we,
	input wire cpu_pkg::reg_num_t wr_num,
	input wire cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	word_t regs [8];					// R0 to R7

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;			// All registers start at zero
		end
		else if (we)
			regs[wr_num] <= wr_data;
	end

	assign data_a = regs[rd_a];			// Reads see the old value until the edge
	assign data_b = regs[rd_b];

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input wire clock,
	input wire reset,
	wb_if.master bus,
	fetch_if.fetch fe
);
	import cpu_pkg::*;

	word_t fetch_addr;					// Next address to request
	word_t req_adr;						// Address of the fetch on the bus
	word_t buf_instr;
	word_t buf_pc;
	logic buf_valid;
	logic busy;							// Fetch in flight
	logic discard;						// In-flight data belongs to a flushed path
	logic taking;
	logic acked;
	logic start;

	assign taking = buf_valid && fe.take;
	assign acked = busy && bus.ack;
	assign start = !busy && (!buf_valid || taking) && !fe.redirect;	// Keep one word ahead

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetch_addr <= RESET_PC;
			busy <= 1'b0;
			discard <= 1'b0;
			buf_valid <= 1'b0;
		end
		else
		begin
			if (start)
			begin
				busy <= 1'b1;
				fetch_addr <= fetch_addr + PC_STEP;
			end
			else if (acked)
				busy <= 1'b0;
			if (fe.redirect)
			begin
				fetch_addr <= fe.target;	// Resume at the branch target
				buf_valid <= 1'b0;
				discard <= busy && !acked;	// Drop the late word when it lands
			end
			else if (acked)
			begin
				buf_valid <= !discard;
				discard <= 1'b0;
			end
			else if (taking)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
			req_adr <= fetch_addr;
		if (acked)
		begin
			buf_instr <= bus.dat_r;
			buf_pc <= req_adr;
		end
	end

	assign bus.adr = req_adr;
	assign bus.dat_w = '0;				// Fetch never writes
	assign bus.we = 1'b0;
	assign bus.cyc = busy;
	assign bus.stb = busy;
	assign fe.valid = buf_valid;
	assign fe.instr = buf_instr;
	assign fe.pc = buf_pc;

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input wire clock,
	input wire reset,
	wb_if.master bus,
	lsu_if.unit ls
);
	import cpu_pkg::*;

	logic busy;							// Transfer held on the bus
	logic write_q;
	word_t addr_q;
	word_t wdata_q;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			write_q <= 1'b0;
		end
		else if (ls.start)
		begin
			busy <= 1'b1;				// cyc one cycle after start
			write_q <= ls.write;
		end
		else if (busy && bus.ack)
			busy <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (ls.start)
		begin
			addr_q <= ls.addr;
			wdata_q <= ls.wdata;
		end
	end

	assign bus.adr = addr_q;
	assign bus.dat_w = wdata_q;
	assign bus.we = write_q;
	assign bus.cyc = busy;
	assign bus.stb = busy;
	assign ls.done = busy && bus.ack;	// Single cycle pulse on the ack
	assign ls.rdata = bus.dat_r;		// LD data taken into the register file on done

endmodule

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input wire clock,
	input wire reset,
	wb_if.slave fetch_bus,
	wb_if.slave data_bus,
	output cpu_pkg::word_t wb_adr,
	output cpu_pkg::word_t wb_dat_w,
	output logic wb_we,
	output logic wb_cyc,
	output logic wb_stb,
	input wire cpu_pkg::word_t wb_dat_r,
	input wire wb_ack
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_DATA} owner_t;

	owner_t owner;						// Held grant
	owner_t grant;						// Grant in effect this cycle

	always_comb
	begin
		if (owner != OWN_NONE)
			grant = owner;				// Locked until the owner's ack
		else if (data_bus.cyc)
			grant = OWN_DATA;			// Load/store wins a tie
		else if (fetch_bus.cyc)
			grant = OWN_FETCH;
		else
			grant = OWN_NONE;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			owner <= OWN_NONE;
		else if (wb_ack)
			owner <= OWN_NONE;			// Free again after the transfer ends
		else
			owner <= grant;
	end

	always_comb
	begin
		wb_adr = '0;
		wb_dat_w = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		case (grant)
			OWN_DATA:
			begin
				wb_adr = data_bus.adr;
				wb_dat_w = data_bus.dat_w;
				wb_we = data_bus.we;
				wb_cyc = data_bus.cyc;
				wb_stb = data_bus.stb;
			end
			OWN_FETCH:
			begin
				wb_adr = fetch_bus.adr;
				wb_dat_w = fetch_bus.dat_w;
				wb_we = fetch_bus.we;
				wb_cyc = fetch_bus.cyc;
				wb_stb = fetch_bus.stb;
			end
			default: wb_cyc = 1'b0;		// Bus idle
		endcase
	end

	assign fetch_bus.dat_r = wb_dat_r;
	assign data_bus.dat_r = wb_dat_r;
	assign fetch_bus.ack = wb_ack && (grant == OWN_FETCH);	// Only the owner sees ack
	assign data_bus.ack = wb_ack && (grant == OWN_DATA);

endmodule

`default_nettype wire

// ==== hdl/control_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_sequencer (
	input wire clock,
	input wire reset,
	fetch_if.sequencer fe,
	lsu_if.sequencer ls,
	input wire cpu_pkg::word_t brkpnt,
	output logic halted,
	output cpu_pkg::reg_num_t rf_rd_a,
	output cpu_pkg::reg_num_t rf_rd_b,
	input wire cpu_pkg::word_t rf_data_a,
	input wire cpu_pkg::word_t rf_data_b,
	output logic rf_we,
	output cpu_pkg::reg_num_t rf_wr_num,
	output cpu_pkg::word_t rf_wr_data,
	output cpu_pkg::alu_op_t alu_op_sel,
	input wire cpu_pkg::word_t alu_result,
	input wire cpu_pkg::flags_t alu_flags,
	output cpu_pkg::flags_t psw
);
	import cpu_pkg::*;

	seq_state_t state;
	word_t ir;							// Instruction being run
	word_t cur_pc;						// Its address
	opcode_t opcode;
	cond_t cond;
	logic is_alu_op;
	logic sets_flags;
	logic is_mem_op;
	logic br_taken;

	function automatic logic cond_true(input cond_t c, input flags_t f);
		logic t;
		case (c)
			COND_EQ: t = f[FLAG_Z];
			COND_NE: t = !f[FLAG_Z];
			COND_CS: t = f[FLAG_C];
			COND_CC: t = !f[FLAG_C];
			COND_MI: t = f[FLAG_N];
			COND_PL: t = !f[FLAG_N];
			COND_VS: t = f[FLAG_V];
			COND_VC: t = !f[FLAG_V];
			COND_AL: t = 1'b1;
			default: t = 1'b0;			// Unused codes never branch
		endcase
		return t;
	endfunction

	assign opcode = opcode_t'(ir[15:12]);
	assign cond = cond_t'(ir[11:8]);
	assign is_alu_op = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MOV};
	assign sets_flags = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};	// MOV leaves psw
	assign is_mem_op = opcode inside {OP_LD, OP_ST};
	assign br_taken = (opcode == OP_BR) && cond_true(cond, psw);

	assign rf_rd_a = ir[11:9];			// Destination, or ST address
	assign rf_rd_b = ir[8:6];			// Source, LD address, or ST data
	assign rf_wr_num = ir[11:9];
	assign rf_we = ((state == S_EXECUTE) && (is_alu_op || opcode inside {OP_MOVL, OP_MOVH}))
		|| ((state == S_MEMORY) && ls.done && (opcode == OP_LD));

	always_comb
	begin
		case (opcode)
			OP_MOVL: rf_wr_data = {rf_data_a[15:8], ir[7:0]};	// High byte kept
			OP_MOVH: rf_wr_data = {ir[7:0], rf_data_a[7:0]};	// Low byte kept
			OP_LD: rf_wr_data = ls.rdata;
			default: rf_wr_data = alu_result;
		endcase
		case (opcode)
			OP_ADD: alu_op_sel = ALU_ADD;
			OP_SUB: alu_op_sel = ALU_SUB;
			OP_AND: alu_op_sel = ALU_AND;
			OP_XOR: alu_op_sel = ALU_XOR;
			default: alu_op_sel = ALU_PASS;
		endcase
	end

	assign fe.take = (state == S_FETCH) && fe.valid && (fe.pc != brkpnt);
	assign fe.redirect = (state == S_EXECUTE) && br_taken;
	assign fe.target = cur_pc + PC_STEP + {{7{ir[7]}}, ir[7:0], 1'b0};	// Word offset to bytes

	assign ls.start = (state == S_EXECUTE) && is_mem_op;	// One cycle
	assign ls.write = (opcode == OP_ST);
	assign ls.addr = (opcode == OP_ST) ? rf_data_a : rf_data_b;
	assign ls.wdata = rf_data_b;

	assign halted = (state == S_HALTED);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_FETCH;
			psw <= '0;
		end
		else
		begin
			case (state)
				S_FETCH:
				begin
					if (fe.valid)
						state <= (fe.pc == brkpnt) ? S_HALTED : S_EXECUTE;	// Stop before it runs
				end
				S_EXECUTE:
				begin
					state <= is_mem_op ? S_MEMORY : S_FETCH;
					if (sets_flags)
						psw <= alu_flags;
					else if (opcode == OP_SETCC)
						psw <= psw | ir[3:0];
					else if (opcode == OP_CLRCC)
						psw <= psw & ~ir[3:0];
				end
				S_MEMORY:
				begin
					if (ls.done)
						state <= S_FETCH;	// Wait states hold us here
				end
				default: state <= S_HALTED;	// Only reset leaves
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (fe.take)
		begin
			ir <= fe.instr;
			cur_pc <= fe.pc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input wire clock,
	input wire reset,
	output cpu_pkg::word_t wb_adr,
	output cpu_pkg::word_t wb_dat_w,
	output logic wb_we,
	output logic wb_cyc,
	output logic wb_stb,
	input wire cpu_pkg::word_t wb_dat_r,
	input wire wb_ack,
	input wire cpu_pkg::word_t brkpnt,
	output logic halted
);
	import cpu_pkg::*;

	wb_if wb_fetch ();					// Fetch master to arbiter
	wb_if wb_data ();					// Load/store master to arbiter
	fetch_if fe_link ();
	lsu_if ls_link ();

	reg_num_t rf_rd_a;
	reg_num_t rf_rd_b;
	reg_num_t rf_wr_num;
	word_t rf_data_a;
	word_t rf_data_b;
	word_t rf_wr_data;
	logic rf_we;
	alu_op_t alu_op_sel;
	word_t alu_result;
	flags_t alu_flags;
	flags_t psw;

	fetch_unit u_fetch (.clock(clock), .reset(reset), .bus(wb_fetch), .fe(fe_link));

	load_store_unit u_lsu (.clock(clock), .reset(reset), .bus(wb_data), .ls(ls_link));

	bus_arbiter u_arbiter (.clock(clock), .reset(reset), .fetch_bus(wb_fetch),
		.data_bus(wb_data), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_we(wb_we),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack));

	control_sequencer u_seq (.clock(clock), .reset(reset), .fe(fe_link), .ls(ls_link),
		.brkpnt(brkpnt), .halted(halted), .rf_rd_a(rf_rd_a), .rf_rd_b(rf_rd_b),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b), .rf_we(rf_we), .rf_wr_num(rf_wr_num),
		.rf_wr_data(rf_wr_data), .alu_op_sel(alu_op_sel), .alu_result(alu_result),
		.alu_flags(alu_flags), .psw(psw));

	reg_file u_regs (.clock(clock), .reset(reset), .rd_a(rf_rd_a), .rd_b(rf_rd_b),
		.data_a(rf_data_a), .data_b(rf_data_b), .we(rf_we), .wr_num(rf_wr_num),
		.wr_data(rf_wr_data));

	// ALU operands come straight from the two read ports and the status word
	alu u_alu (.op(alu_op_sel), .a(rf_data_a), .b(rf_data_b), .flags_in(psw),
		.result(alu_result), .flags_out(alu_flags));

endmodule

`default_nettype wire

// ==== verification/wb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_memory_model (
	input wire clock,
	input wire reset,
	input wire cpu_pkg::word_t adr,
	input wire cpu_pkg::word_t dat_w,
	input wire we,
	input wire cyc,
	input wire stb,
	output cpu_pkg::word_t dat_r,
	output logic ack
);
	import cpu_pkg::*;

	localparam int DEPTH = 256;			// Words indexed by adr[8:1]

	word_t mem [DEPTH];
	logic [31:0] lfsr;					// Wait state source
	logic [31:0] lfsr_mid;
	logic active;						// Transfer seen and waits being counted
	logic [1:0] wait_left;

	// Galois LFSR step that yields one new bit at the low end
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic load_word(input int idx, input word_t w);
		mem[idx] = w;					// Backdoor write
	endtask

	initial
	begin
		lfsr = 32'he4e8;
		ack = 1'b0;						// Bus outputs start idle
		dat_r = '0;
	end

	always @(posedge clock)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			active <= 1'b0;
		end
		else
		begin
			ack <= 1'b0;				// Single cycle ack
			if (cyc && stb && !ack)
			begin
				if (!active)
				begin
					lfsr_mid = lfsr_step(lfsr);
					wait_left <= {lfsr[0], lfsr_mid[0]};	// 0 to 3 waits
					lfsr <= lfsr_step(lfsr_mid);
					active <= 1'b1;
				end
				else if (wait_left == 2'd0)
				begin
					ack <= 1'b1;
					active <= 1'b0;
					if (we)
						mem[adr[8:1]] <= dat_w;
					dat_r <= mem[adr[8:1]];
				end
				else
					wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/cpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int DATA_WORD = 192;		// Result area at byte 0x0180
	localparam int NUM_TESTS = 5;
	localparam int TEST_CYCLES = 3000;	// Budget for one test
	localparam word_t MARKER = 16'h005A;	// Value held in r5
	localparam word_t NOP = 16'hC000;

	logic clock;
	logic reset;
	word_t brkpnt;
	word_t wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic halted;

	int errors;
	int checks;
	int cyc_after_halt;					// Bus cycles seen while halted
	int prog_len;
	word_t image [MEM_WORDS];			// Memory image for the next run

	initial clock = 1'b0;
	always #5 clock = ~clock;

	cpu_core u_dut (.clock(clock), .reset(reset), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .brkpnt(brkpnt), .halted(halted));

	wb_memory_model u_mem (.clock(clock), .reset(reset), .adr(wb_adr), .dat_w(wb_dat_w),
		.we(wb_we), .cyc(wb_cyc), .stb(wb_stb), .dat_r(wb_dat_r), .ack(wb_ack));

	always @(negedge clock)
		if (!reset && halted && wb_cyc)
			cyc_after_halt++;

	function automatic word_t enc_rr(input logic [3:0] op, input reg_num_t a, input reg_num_t b);
		return {op, a, b, 6'd0};
	endfunction

	function automatic word_t enc_byte(input logic [3:0] op, input reg_num_t a,
		input logic [7:0] val);
		return {op, a, 1'b0, val};
	endfunction

	function automatic word_t enc_br(input logic [3:0] c, input logic [7:0] off);
		return {OP_BR, c, off};
	endfunction

	function automatic word_t enc_cc(input logic [3:0] op, input flags_t bits);
		return {op, 8'd0, bits};
	endfunction

	function automatic word_t fill_word(input int idx);
		return {8'hC0, idx[7:0]};		// No-op opcode with the word index in the low byte
	endfunction

	function automatic word_t mem_at(input int idx);
		return u_mem.mem[idx];
	endfunction

	// Expected flags of a - b where C means no borrow
	function automatic flags_t sub_flags_ref(input word_t a, input word_t b);
		flags_t f;
		word_t r;
		r = a - b;
		f[FLAG_C] = (a >= b);
		f[FLAG_Z] = (r == 16'd0);
		f[FLAG_N] = r[15];
		f[FLAG_V] = (a[15] != b[15]) && (r[15] != a[15]);
		return f;
	endfunction

	// Even codes test a flag set and odd codes the same flag clear
	function automatic logic branch_ref(input int c, input flags_t f);
		logic bit_val;
		if (c == 8)
			return 1'b1;
		if (c > 8)
			return 1'b0;
		case (c / 2)
			0: bit_val = f[FLAG_Z];
			1: bit_val = f[FLAG_C];
			2: bit_val = f[FLAG_N];
			default: bit_val = f[FLAG_V];
		endcase
		return (c % 2 == 0) ? bit_val : !bit_val;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic emit(input word_t w);
		image[prog_len] = w;
		prog_len++;
	endtask

	// Fresh image with r7 at the result area, r6 = 2 and r5 = marker
	task automatic begin_program();
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = fill_word(i);
		prog_len = 0;
		emit(enc_byte(OP_MOVH, 3'd7, 8'h01));
		emit(enc_byte(OP_MOVL, 3'd7, 8'h80));
		emit(enc_byte(OP_MOVL, 3'd6, 8'h02));
		emit(enc_byte(OP_MOVL, 3'd5, MARKER[7:0]));
	endtask

	task automatic store_and_step(input reg_num_t rs);
		emit(enc_rr(OP_ST, 3'd7, rs));
		emit(enc_rr(OP_ADD, 3'd7, 3'd6));	// Next result slot
	endtask

	// Breakpoint on the last word, reset, then wait for halted
	task automatic run_program(input string test_name);
		int cycles;
		@(posedge clock);
		#1;
		reset = 1'b1;
		brkpnt = word_t'(2 * (prog_len - 1));
		for (int i = 0; i < MEM_WORDS; i++)
			u_mem.load_word(i, image[i]);
		repeat (8) @(posedge clock);
		#1;
		check_bit({test_name, " wb_cyc in reset"}, wb_cyc, 1'b0);	// Bus idle out of reset
		check_bit({test_name, " wb_stb in reset"}, wb_stb, 1'b0);
		check_bit({test_name, " wb_we in reset"}, wb_we, 1'b0);
		check_bit({test_name, " halted in reset"}, halted, 1'b0);
		reset = 1'b0;
		cyc_after_halt = 0;
		cycles = 0;
		while (!halted && cycles < TEST_CYCLES)
		begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!halted)
		begin
			errors++;
			$display("%s: the core never reached its breakpoint", test_name);
		end
		repeat (8) @(posedge clock);	// Bus stays quiet while halted
		#1;
		check_bit({test_name, " halted"}, halted, 1'b1);
		if (cyc_after_halt != 0)
		begin
			errors++;
			$display("%s: a bus cycle started after the core halted", test_name);
		end
	endtask

	task automatic test_alu();
		word_t va;
		word_t vb;
		word_t vx;
		word_t exp [7];
		va = 16'h12F0;
		vb = 16'h0F35;
		vx = va ^ vb;
		exp = '{va, va + vb, va - vb, va & vb, vx, {vx[15:8], 8'hAB}, {8'h7E, 8'hAB}};
		begin_program();
		emit(enc_byte(OP_MOVL, 3'd1, 8'hF0));
		emit(enc_byte(OP_MOVH, 3'd1, 8'h12));
		emit(enc_byte(OP_MOVL, 3'd2, 8'h35));
		emit(enc_byte(OP_MOVH, 3'd2, 8'h0F));
		emit(enc_rr(OP_MOV, 3'd3, 3'd1));
		store_and_step(3'd3);
		emit(enc_rr(OP_MOV, 3'd3, 3'd1));
		emit(enc_rr(OP_ADD, 3'd3, 3'd2));
		store_and_step(3'd3);
		emit(enc_rr(OP_MOV, 3'd3, 3'd1));
		emit(enc_rr(OP_SUB, 3'd3, 3'd2));
		store_and_step(3'd3);
		emit(enc_rr(OP_MOV, 3'd3, 3'd1));
		emit(enc_rr(OP_AND, 3'd3, 3'd2));
		store_and_step(3'd3);
		emit(enc_rr(OP_MOV, 3'd3, 3'd1));
		emit(enc_rr(OP_XOR, 3'd3, 3'd2));
		store_and_step(3'd3);
		emit(enc_byte(OP_MOVL, 3'd3, 8'hAB));	// Low byte of the XOR result replaced
		store_and_step(3'd3);
		emit(enc_byte(OP_MOVH, 3'd3, 8'h7E));
		store_and_step(3'd3);
		emit(NOP);
		run_program("alu");
		for (int i = 0; i < 7; i++)
			check_word($sformatf("alu result %0d", i), mem_at(DATA_WORD + i), exp[i]);
	endtask

	task automatic test_branches();
		flags_t setups [3];
		int k;
		logic taken;
		setups[0] = sub_flags_ref(16'h8000, 16'h0001);
		setups[1] = 4'b0000 | 4'b0101;
		setups[2] = 4'b1111 & ~4'b1001;
		begin_program();
		emit(enc_byte(OP_MOVH, 3'd1, 8'h80));
		emit(enc_byte(OP_MOVL, 3'd2, 8'h01));
		for (int s = 0; s < 3; s++)
			for (int c = 0; c < 10; c++)
			begin
				case (s)
					0:
					begin
						emit(enc_rr(OP_MOV, 3'd3, 3'd1));
						emit(enc_rr(OP_SUB, 3'd3, 3'd2));
					end
					1:
					begin
						emit(enc_cc(OP_CLRCC, 4'hF));
						emit(enc_cc(OP_SETCC, 4'h5));
					end
					default:
					begin
						emit(enc_cc(OP_SETCC, 4'hF));
						emit(enc_cc(OP_CLRCC, 4'h9));
					end
				endcase
				emit(enc_br(4'(c), 8'd1));	// Skips the marker store
				store_and_step(3'd5);
			end
		emit(NOP);
		run_program("branches");
		k = 0;
		for (int s = 0; s < 3; s++)
			for (int c = 0; c < 10; c++)
			begin
				taken = branch_ref(c, setups[s]);
				check_word($sformatf("branch setup %0d cond %0d", s, c), mem_at(DATA_WORD + k),
					taken ? fill_word(DATA_WORD + k) : MARKER);
				k++;
			end
	endtask

	task automatic test_load_store();
		word_t data [8];
		begin_program();
		emit(enc_byte(OP_MOVL, 3'd4, 8'hA0));	// r4 = 0x01A0 points at the copy area
		emit(enc_byte(OP_MOVH, 3'd4, 8'h01));
		for (int i = 0; i < 8; i++)
		begin
			data[i] = word_t'(16'h1357 * (i + 1)) ^ 16'hA5C3;
			image[DATA_WORD + i] = data[i];
			emit(enc_rr(OP_LD, 3'd3, 3'd7));
			emit(enc_rr(OP_ST, 3'd4, 3'd3));
			emit(enc_rr(OP_ADD, 3'd7, 3'd6));
			emit(enc_rr(OP_ADD, 3'd4, 3'd6));
		end
		emit(NOP);
		run_program("load_store");
		for (int i = 0; i < 8; i++)
		begin
			check_word($sformatf("copied word %0d", i), mem_at(DATA_WORD + 16 + i), data[i]);
			check_word($sformatf("source word %0d", i), mem_at(DATA_WORD + i), data[i]);
		end
	endtask

	task automatic test_redirect();
		begin_program();
		emit(enc_br(4'd8, 8'd2));		// Always taken and jumps over both stores
		emit(enc_rr(OP_ST, 3'd7, 3'd5));
		emit(enc_rr(OP_ST, 3'd7, 3'd5));
		emit(enc_rr(OP_ADD, 3'd7, 3'd6));
		emit(enc_rr(OP_ST, 3'd7, 3'd5));
		emit(NOP);
		run_program("redirect");
		check_word("skipped slot", mem_at(DATA_WORD), fill_word(DATA_WORD));
		check_word("target slot", mem_at(DATA_WORD + 1), MARKER);
	endtask

	task automatic test_breakpoint();
		begin_program();
		emit(enc_rr(OP_ST, 3'd7, 3'd5));
		emit(enc_rr(OP_ADD, 3'd7, 3'd6));
		emit(enc_rr(OP_ST, 3'd7, 3'd5));	// Sits on the breakpoint
		run_program("breakpoint");
		check_word("store before breakpoint", mem_at(DATA_WORD), MARKER);
		check_word("store at breakpoint", mem_at(DATA_WORD + 1), fill_word(DATA_WORD + 1));
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		cyc_after_halt = 0;
		prog_len = 0;
		reset = 1'b1;
		brkpnt = '0;
		test_alu();
		test_branches();
		test_load_store();
		test_redirect();
		test_breakpoint();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog over the whole run
	initial
	begin
		#(NUM_TESTS * TEST_CYCLES * 10);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/cpu_pkg.sv
hdl/cpu_interfaces.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/bus_arbiter.sv
hdl/control_sequencer.sv
hdl/cpu_core.sv
verification/wb_memory_model.sv
verification/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpu_core_tb
RTL_TOP ?= cpu_core
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
